/* video_mem_pkg.sv */
/*
 * Video memory subsystem definitions
 * Link, pixel and sizing constants, plus the request, response,
 * pixel beat and meter counter types shared by all blocks.
 */

`default_nettype none

package video_mem_pkg;

	// ----------------------------------------
	// Link and pixel sizing
	// ----------------------------------------
	localparam int FML_DEPTH = 10;
	localparam int FML_DATA_W = 64;
	localparam int FML_SEL_W = 8;
	localparam int PIXEL_W = 16;
	localparam int PIX_PER_WORD = 4;
	localparam int MEM_LATENCY = 2;
	localparam int VIN_FIFO_DEPTH = 8;
	localparam int FETCH_CREDIT_MAX = 8;

	// Arbiter masters, fetch has top priority
	localparam int N_MASTERS = 3;
	localparam int MASTER_FETCH = 0;
	localparam int MASTER_HOST = 1;
	localparam int MASTER_VIN = 2;

	// Derived counter widths
	localparam int GNT_W = $clog2(N_MASTERS);
	localparam int MEM_LAT_W = $clog2(MEM_LATENCY + 1);
	localparam int PIX_IDX_W = $clog2(PIX_PER_WORD);
	localparam int VIN_PTR_W = $clog2(VIN_FIFO_DEPTH);
	localparam int VIN_CNT_W = $clog2(VIN_FIFO_DEPTH + 1);
	localparam int FETCH_CREDIT_W = $clog2(FETCH_CREDIT_MAX + 1);

	// ----------------------------------------
	// Types
	// ----------------------------------------
	typedef logic [FML_DEPTH-1:0] fml_adr_t;

	// Raw word for memory and host, four pixels for the video units
	typedef union packed {
		logic [FML_DATA_W-1:0] raw;
		logic [PIX_PER_WORD-1:0][PIXEL_W-1:0] pix;
	} fml_word_u;

	typedef struct packed {
		logic stb;
		logic we;
		fml_adr_t adr;
		logic [FML_SEL_W-1:0] sel;
		fml_word_u dw;
	} fml_req_t;

	typedef struct packed {
		logic ack;
		fml_word_u dr;
	} fml_rsp_t;

	typedef struct packed {
		logic valid;
		logic [PIXEL_W-1:0] pix;
	} pix_beat_t;

	typedef logic [31:0] meter_count_t;

endpackage

`default_nettype wire

/* fml_arbiter.sv */
/*
 * Memory link arbiter
 * Grants the shared link to one of three masters. The fetch master
 * always wins, host and capture take turns. The grant is registered
 * and held until the slave acknowledges.
 */

`timescale 1ns/100ps
`default_nettype none

module fml_arbiter import video_mem_pkg::*; (
	input wire sys_clk,
	input wire trigger_reset,
	input wire fml_req_t m_req_i [N_MASTERS],
	output fml_rsp_t m_rsp_o [N_MASTERS],
	input wire fml_rsp_t s_rsp_i,
	output fml_req_t s_req_o
);

	logic gnt_vld;
	logic [GNT_W-1:0] gnt_idx;
	logic rr_vin_first;
	logic fetch_req;
	logic host_req;
	logic vin_req;

	assign fetch_req = m_req_i[MASTER_FETCH].stb;
	assign host_req = m_req_i[MASTER_HOST].stb;
	assign vin_req = m_req_i[MASTER_VIN].stb;

	// ----------------------------------------
	// Grant selection
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			gnt_vld <= 1'b0;
			gnt_idx <= '0;
			rr_vin_first <= 1'b0;
		end else if (gnt_vld) begin
			// Transfer open until the slave acks
			if (s_rsp_i.ack)
				gnt_vld <= 1'b0;
		end else if (fetch_req) begin
			gnt_vld <= 1'b1;
			gnt_idx <= GNT_W'(MASTER_FETCH);
		end else if (vin_req && (rr_vin_first || !host_req)) begin
			gnt_vld <= 1'b1;
			gnt_idx <= GNT_W'(MASTER_VIN);
			rr_vin_first <= 1'b0;
		end else if (host_req) begin
			gnt_vld <= 1'b1;
			gnt_idx <= GNT_W'(MASTER_HOST);
			rr_vin_first <= 1'b1;
		end
	end

	// ----------------------------------------
	// Request and response routing
	// ----------------------------------------
	always_comb begin
		s_req_o = '0;
		if (gnt_vld)
			s_req_o = m_req_i[gnt_idx];
	end

	// Read data goes to all, ack only to the granted master
	always_comb begin
		for (int i = 0; i < N_MASTERS; i++) begin
			m_rsp_o[i].dr = s_rsp_i.dr;
			m_rsp_o[i].ack = gnt_vld && (gnt_idx == GNT_W'(i)) && s_rsp_i.ack;
		end
	end

endmodule

`default_nettype wire

/* fml_ram.sv */
/*
 * On-chip memory link slave
 * Answers each strobe after a fixed number of cycles. Writes are
 * merged per byte select, reads return the stored word with the ack.
 */

`timescale 1ns/100ps
`default_nettype none

module fml_ram import video_mem_pkg::*; (
	input wire sys_clk,
	input wire trigger_reset,
	input wire fml_req_t req_i,
	output fml_rsp_t rsp_o
);

	fml_word_u mem [2**FML_DEPTH];
	fml_word_u rd_q;
	logic [MEM_LAT_W-1:0] lat_cnt;
	logic ack_q;
	logic access;

	// Last wait cycle, memory is touched here
	assign access = req_i.stb && !ack_q && (lat_cnt == MEM_LAT_W'(MEM_LATENCY - 1));

	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			lat_cnt <= '0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
			if (ack_q)
				lat_cnt <= '0;
			else if (req_i.stb && !access)
				lat_cnt <= lat_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (access) begin
			if (req_i.we) begin
				for (int b = 0; b < FML_SEL_W; b++)
					if (req_i.sel[b])
						mem[req_i.adr].raw[8*b +: 8] <= req_i.dw.raw[8*b +: 8];
			end else begin
				rd_q <= mem[req_i.adr];
			end
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dr = rd_q;

endmodule

`default_nettype wire

/* fb_fetch.sv */
/*
 * Framebuffer scan-out reader
 * Reads a run of words from memory and sends them out as a credited
 * pixel stream, pixel 0 of each word first.
 */

`timescale 1ns/100ps
`default_nettype none

module fb_fetch import video_mem_pkg::*; (
	input wire sys_clk,
	input wire trigger_reset,
	input wire fml_adr_t base_i,
	input wire fml_adr_t words_i,
	input wire start_i,
	input wire fml_rsp_t rsp_i,
	input wire credit_i,
	output fml_req_t req_o,
	output pix_beat_t pix_o,
	output logic done_o
);

	fml_adr_t rd_adr;
	fml_adr_t words_left;
	fml_word_u word_q;
	logic active;
	logic stb_q;
	logic word_vld;
	logic done_q;
	logic [PIX_IDX_W-1:0] pix_idx;
	logic [FETCH_CREDIT_W-1:0] credits;
	logic pix_fire;
	logic last_pix;

	assign pix_fire = word_vld && (credits != '0);
	assign last_pix = pix_idx == PIX_IDX_W'(PIX_PER_WORD - 1);

	// ----------------------------------------
	// Word fetch and pixel sequencing
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			active <= 1'b0;
			stb_q <= 1'b0;
			word_vld <= 1'b0;
			done_q <= 1'b0;
			pix_idx <= '0;
			rd_adr <= '0;
			words_left <= '0;
		end else begin
			done_q <= 1'b0;
			if (start_i && !active) begin
				active <= words_i != '0;
				stb_q <= words_i != '0;
				rd_adr <= base_i;
				words_left <= words_i;
				pix_idx <= '0;
			end
			if (stb_q && rsp_i.ack) begin
				stb_q <= 1'b0;
				word_vld <= 1'b1;
				rd_adr <= rd_adr + 1'b1;
				words_left <= words_left - 1'b1;
			end
			if (pix_fire) begin
				pix_idx <= pix_idx + 1'b1;
				if (last_pix) begin
					word_vld <= 1'b0;
					// Next word only once this one is drained
					if (words_left == '0) begin
						active <= 1'b0;
						done_q <= 1'b1;
					end else begin
						stb_q <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (stb_q && rsp_i.ack)
			word_q <= rsp_i.dr;
	end

	// Credit count, saturating
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			credits <= '0;
		end else begin
			case ({credit_i, pix_fire})
				2'b10: if (credits != FETCH_CREDIT_W'(FETCH_CREDIT_MAX))
					credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: ;
			endcase
		end
	end

	always_comb begin
		req_o = '0;
		req_o.stb = stb_q;
		req_o.adr = rd_adr;
		req_o.sel = '1;
	end

	assign pix_o.valid = pix_fire;
	assign pix_o.pix = word_q.pix[pix_idx];
	assign done_o = done_q;

endmodule

`default_nettype wire

/* vin_capture.sv */
/*
 * Video input capture writer
 * Receives a credited pixel stream into a small FIFO, packs four
 * pixels per word and writes the words to memory upward from base.
 */

`timescale 1ns/100ps
`default_nettype none

module vin_capture import video_mem_pkg::*; (
	input wire sys_clk,
	input wire trigger_reset,
	input wire fml_adr_t base_i,
	input wire pix_beat_t pix_i,
	input wire fml_rsp_t rsp_i,
	output logic credit_o,
	output fml_req_t req_o
);

	logic [PIXEL_W-1:0] fifo_mem [VIN_FIFO_DEPTH];
	logic [VIN_PTR_W-1:0] wr_ptr;
	logic [VIN_PTR_W-1:0] rd_ptr;
	logic [VIN_CNT_W-1:0] fifo_cnt;
	logic [VIN_CNT_W-1:0] owed;
	logic [PIX_IDX_W-1:0] pack_idx;
	fml_word_u pack_q;
	fml_adr_t wr_adr;
	logic credit_q;
	logic stb_q;
	logic push;
	logic pop;
	logic give;

	assign push = pix_i.valid;
	// Packing pauses while a word write is open
	assign pop = (fifo_cnt != '0) && !stb_q;
	assign give = owed != '0;

	// ----------------------------------------
	// FIFO and credit return
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			// Full FIFO worth of credits owed after reset
			owed <= VIN_CNT_W'(VIN_FIFO_DEPTH);
			credit_q <= 1'b0;
		end else begin
			credit_q <= give;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: fifo_cnt <= fifo_cnt + 1'b1;
				2'b01: fifo_cnt <= fifo_cnt - 1'b1;
				default: ;
			endcase
			case ({give, pop})
				2'b10: owed <= owed - 1'b1;
				2'b01: owed <= owed + 1'b1;
				default: ;
			endcase
		end
	end

	// ----------------------------------------
	// Packing and word writes
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			pack_idx <= '0;
			stb_q <= 1'b0;
			wr_adr <= base_i;
		end else begin
			if (pop) begin
				pack_idx <= pack_idx + 1'b1;
				if (pack_idx == PIX_IDX_W'(PIX_PER_WORD - 1))
					stb_q <= 1'b1;
			end
			if (stb_q && rsp_i.ack) begin
				stb_q <= 1'b0;
				wr_adr <= wr_adr + 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (push)
			fifo_mem[wr_ptr] <= pix_i.pix;
		if (pop)
			pack_q.pix[pack_idx] <= fifo_mem[rd_ptr];
	end

	always_comb begin
		req_o = '0;
		req_o.stb = stb_q;
		req_o.we = 1'b1;
		req_o.adr = wr_adr;
		req_o.sel = '1;
		req_o.dw = pack_q;
	end

	assign credit_o = credit_q;

endmodule

`default_nettype wire

/* fml_meter.sv */
/*
 * Memory link usage meter
 * Counts cycles with the slave strobe high and completed transfers.
 */

`timescale 1ns/100ps
`default_nettype none

module fml_meter import video_mem_pkg::*; (
	input wire sys_clk,
	input wire trigger_reset,
	input wire stb_i,
	input wire ack_i,
	output meter_count_t busy_cycles_o,
	output meter_count_t transfers_o
);

	meter_count_t busy_q;
	meter_count_t xfer_q;

	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			busy_q <= '0;
			xfer_q <= '0;
		end else begin
			if (stb_i)
				busy_q <= busy_q + 1'b1;
			// One ack closes one transfer
			if (ack_i)
				xfer_q <= xfer_q + 1'b1;
		end
	end

	assign busy_cycles_o = busy_q;
	assign transfers_o = xfer_q;

endmodule

`default_nettype wire

/* video_mem_top.sv */
/*
 * Shared video memory subsystem
 * Fetch, host and capture masters share one memory link through
 * the arbiter, with a meter watching the slave side.
 */

`timescale 1ns/100ps
`default_nettype none

module video_mem_top import video_mem_pkg::*; (
	input wire sys_clk,
	input wire trigger_reset,
	input wire fml_req_t host_req_i,
	output fml_rsp_t host_rsp_o,
	input wire fml_adr_t fb_base_i,
	input wire fml_adr_t fb_words_i,
	input wire fb_start_i,
	input wire fb_credit_i,
	output pix_beat_t fb_pix_o,
	output logic fb_done_o,
	input wire fml_adr_t vin_base_i,
	input wire pix_beat_t vin_pix_i,
	output logic vin_credit_o,
	output meter_count_t busy_cycles_o,
	output meter_count_t transfers_o
);

	fml_req_t m_req [N_MASTERS];
	fml_rsp_t m_rsp [N_MASTERS];
	fml_req_t s_req;
	fml_rsp_t s_rsp;

	// Host port maps straight onto its arbiter slot
	assign m_req[MASTER_HOST] = host_req_i;
	assign host_rsp_o = m_rsp[MASTER_HOST];

	// ----------------------------------------
	// Masters
	// ----------------------------------------
	fb_fetch u_fb_fetch (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.base_i(fb_base_i),
		.words_i(fb_words_i),
		.start_i(fb_start_i),
		.rsp_i(m_rsp[MASTER_FETCH]),
		.credit_i(fb_credit_i),
		.req_o(m_req[MASTER_FETCH]),
		.pix_o(fb_pix_o),
		.done_o(fb_done_o)
	);

	vin_capture u_vin_capture (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.base_i(vin_base_i),
		.pix_i(vin_pix_i),
		.rsp_i(m_rsp[MASTER_VIN]),
		.credit_o(vin_credit_o),
		.req_o(m_req[MASTER_VIN])
	);

	// ----------------------------------------
	// Shared link
	// ----------------------------------------
	fml_arbiter u_fml_arbiter (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.m_req_i(m_req),
		.m_rsp_o(m_rsp),
		.s_rsp_i(s_rsp),
		.s_req_o(s_req)
	);

	fml_ram u_fml_ram (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.req_i(s_req),
		.rsp_o(s_rsp)
	);

	fml_meter u_fml_meter (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.stb_i(s_req.stb),
		.ack_i(s_rsp.ack),
		.busy_cycles_o(busy_cycles_o),
		.transfers_o(transfers_o)
	);

endmodule

`default_nettype wire

/* video_mem_assertions.sv */
/*
 * Link checker for the video memory top level
 * Watches the host port handshake, the one-cycle output pulses,
 * the meter counts and the output state right after reset.
 */

`timescale 1ns/100ps
`default_nettype none

module video_mem_assertions import video_mem_pkg::*; (
	input wire sys_clk,
	input wire trigger_reset,
	input wire fml_req_t host_req_i,
	input wire fml_rsp_t host_rsp_i,
	input wire pix_beat_t fb_pix_i,
	input wire fb_done_i,
	input wire vin_credit_i,
	input wire meter_count_t busy_cycles_i,
	input wire meter_count_t transfers_i
);

	// Failure count, polled from the testbench top
	int fail_count;

	initial fail_count = 0;

	// ----------------------------------------
	// Host port handshake
	// ----------------------------------------
	a_ack_needs_stb: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		host_rsp_i.ack |-> host_req_i.stb)
	else begin
		$error("host ack seen without a host strobe");
		fail_count++;
	end

	a_stb_held: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		host_req_i.stb && !host_rsp_i.ack |=> host_req_i.stb && $stable(host_req_i))
	else begin
		$error("host request dropped or changed before its ack");
		fail_count++;
	end

	a_ack_pulse: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		host_rsp_i.ack |=> !host_rsp_i.ack)
	else begin
		$error("host ack longer than one cycle");
		fail_count++;
	end

	// ----------------------------------------
	// Outputs and meter
	// ----------------------------------------
	a_done_pulse: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		fb_done_i |=> !fb_done_i)
	else begin
		$error("fetch done longer than one cycle");
		fail_count++;
	end

	a_meter_rising: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		1'b1 |=> transfers_i >= $past(transfers_i) && busy_cycles_i >= $past(busy_cycles_i))
	else begin
		$error("meter count went backwards");
		fail_count++;
	end

	// First cycle out of reset
	a_reset_idle: assert property (@(posedge sys_clk)
		$fell(trigger_reset) |-> !fb_pix_i.valid && !fb_done_i && !vin_credit_i
			&& !host_rsp_i.ack && busy_cycles_i == '0 && transfers_i == '0)
	else begin
		$error("outputs active in the cycle after reset");
		fail_count++;
	end

endmodule

bind video_mem_top video_mem_assertions u_video_mem_assertions (
	.sys_clk(sys_clk),
	.trigger_reset(trigger_reset),
	.host_req_i(host_req_i),
	.host_rsp_i(host_rsp_o),
	.fb_pix_i(fb_pix_o),
	.fb_done_i(fb_done_o),
	.vin_credit_i(vin_credit_o),
	.busy_cycles_i(busy_cycles_o),
	.transfers_i(transfers_o)
);

`default_nettype wire

/* tb_video_mem.sv */
/*
 * Testbench for the shared video memory subsystem
 * Runs host accesses, a credited capture stream and a framebuffer
 * fetch over the shared link and checks them against a word model.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_video_mem import video_mem_pkg::*; ();

	localparam int RANDOM_SEED = 53328;
	localparam int RESET_CYCLES = 16;
	// Bound on the whole run, with ample margin
	localparam int TIMEOUT_CYCLES = 6000;
	localparam int HOST_ROUNDS = 8;
	localparam int FB_BASE = 'h100;
	localparam int FB_WORDS = 12;
	localparam int VIN_BASE = 'h200;
	localparam int VIN_PIXELS = 32;
	localparam int VIN_WORDS = VIN_PIXELS / PIX_PER_WORD;

	logic sys_clk;
	logic trigger_reset;
	fml_req_t host_req_i;
	fml_rsp_t host_rsp_o;
	fml_adr_t fb_base_i;
	fml_adr_t fb_words_i;
	logic fb_start_i;
	logic fb_credit_i;
	pix_beat_t fb_pix_o;
	logic fb_done_o;
	fml_adr_t vin_base_i;
	pix_beat_t vin_pix_i;
	logic vin_credit_o;
	meter_count_t busy_cycles_o;
	meter_count_t transfers_o;

	logic [FML_DATA_W-1:0] model_mem [2**FML_DEPTH];
	logic [PIXEL_W-1:0] vin_sent_q [$];
	logic [PIXEL_W-1:0] fb_pix_q [$];
	int fb_held;
	int vin_held;
	int vin_target;
	int fb_done_count;
	int host_acks;
	int cycle_count;
	logic fb_credit_en;

	video_mem_top u_video_mem_top (.*);

	initial sys_clk = 1'b0;
	always #20 sys_clk = ~sys_clk;

	// ----------------------------------------
	// Failure reporting
	// ----------------------------------------
	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic plain_failure(input string what);
		$display("%s", what);
		abort_run();
	endtask

	task automatic value_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
		abort_run();
	endtask

	// ----------------------------------------
	// Host port accesses
	// ----------------------------------------
	task automatic host_access(input logic we, input fml_adr_t adr,
			input logic [FML_SEL_W-1:0] sel, input logic [FML_DATA_W-1:0] data,
			input bit idle_link, output logic [FML_DATA_W-1:0] rdata);
		int wait_cycles;
		@(posedge sys_clk);
		#2;
		host_req_i.stb = 1'b1;
		host_req_i.we = we;
		host_req_i.adr = adr;
		host_req_i.sel = sel;
		host_req_i.dw.raw = data;
		wait_cycles = 0;
		@(negedge sys_clk);
		while (!host_rsp_o.ack) begin
			wait_cycles++;
			@(negedge sys_clk);
		end
		rdata = host_rsp_o.dr.raw;
		@(posedge sys_clk);
		#2;
		host_req_i = '0;
		if (idle_link)
			assert (wait_cycles == MEM_LATENCY + 1)
			else value_mismatch("host_rsp_o.ack latency", wait_cycles, MEM_LATENCY + 1);
	endtask

	task automatic host_write(input fml_adr_t adr, input logic [FML_SEL_W-1:0] sel,
			input logic [FML_DATA_W-1:0] data);
		logic [FML_DATA_W-1:0] unused;
		host_access(1'b1, adr, sel, data, 1'b1, unused);
		for (int b = 0; b < FML_SEL_W; b++)
			if (sel[b])
				model_mem[adr][8*b +: 8] = data[8*b +: 8];
	endtask

	task automatic host_read_check(input fml_adr_t adr, input bit idle_link);
		logic [FML_DATA_W-1:0] rdata;
		host_access(1'b0, adr, '0, '0, idle_link, rdata);
		assert (rdata == model_mem[adr])
		else value_mismatch("host_rsp_o.dr", rdata, model_mem[adr]);
	endtask

	// ----------------------------------------
	// Credit drivers and output monitor
	// ----------------------------------------
	always @(posedge sys_clk) begin
		#2;
		fb_credit_i = fb_credit_en && (fb_held < FETCH_CREDIT_MAX)
			&& ($urandom_range(0, 1) == 1);
	end

	// Pixels only while a capture credit is held
	always @(posedge sys_clk) begin
		#2;
		vin_pix_i = '0;
		if (vin_sent_q.size() < vin_target && vin_held > 0 && $urandom_range(0, 3) != 0) begin
			vin_pix_i.valid = 1'b1;
			vin_pix_i.pix = PIXEL_W'($urandom_range(0, 65535));
			vin_sent_q.push_back(vin_pix_i.pix);
		end
	end

	always @(negedge sys_clk) begin
		int vin_next;
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			plain_failure("Timeout: the tests did not finish within the cycle limit");
		if (u_video_mem_top.u_video_mem_assertions.fail_count != 0)
			plain_failure("A bound link assertion failed");
		if (!trigger_reset) begin
			assert (!fb_pix_o.valid || fb_held > 0)
			else plain_failure("fb_pix_o was valid while no fetch credit was held");
			if (fb_pix_o.valid)
				fb_pix_q.push_back(fb_pix_o.pix);
			if (fb_done_o)
				fb_done_count++;
			if (host_rsp_o.ack)
				host_acks++;
			fb_held = fb_held + int'(fb_credit_i) - int'(fb_pix_o.valid);
			vin_next = vin_held + int'(vin_credit_o) - int'(vin_pix_i.valid);
			assert (vin_next <= VIN_FIFO_DEPTH)
			else value_mismatch("vin_credit_o outstanding", vin_next, VIN_FIFO_DEPTH);
			vin_held = vin_next;
		end
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		logic [FML_DATA_W-1:0] data;
		logic [FML_DATA_W-1:0] expect_word;
		logic [PIXEL_W-1:0] expect_pix;
		fml_adr_t adr;
		int target;
		int expect_xfers;
		void'($urandom(RANDOM_SEED));
		trigger_reset = 1'b1;
		host_req_i = '0;
		fb_base_i = fml_adr_t'(FB_BASE);
		fb_words_i = fml_adr_t'(FB_WORDS);
		fb_start_i = 1'b0;
		fb_credit_i = 1'b0;
		vin_base_i = fml_adr_t'(VIN_BASE);
		vin_pix_i = '0;
		fb_credit_en = 1'b0;
		fb_held = 0;
		vin_held = 0;
		vin_target = 0;
		fb_done_count = 0;
		host_acks = 0;
		cycle_count = 0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#2;
		trigger_reset = 1'b0;

		// Full word then partial byte write on an idle link
		for (int i = 0; i < HOST_ROUNDS; i++) begin
			adr = fml_adr_t'($urandom_range(0, 255));
			host_write(adr, '1, {$urandom, $urandom});
			host_read_check(adr, 1'b1);
			host_write(adr, FML_SEL_W'($urandom_range(1, 254)), {$urandom, $urandom});
			host_read_check(adr, 1'b1);
		end

		for (int w = 0; w < FB_WORDS; w++)
			host_write(fml_adr_t'(FB_BASE + w), '1, {$urandom, $urandom});

		// Fetch, capture and host reads all contend for the link
		fork
			begin
				@(posedge sys_clk);
				#2;
				fb_start_i = 1'b1;
				fb_credit_en = 1'b1;
				@(posedge sys_clk);
				#2;
				fb_start_i = 1'b0;
				while (fb_done_count == 0)
					@(negedge sys_clk);
				fb_credit_en = 1'b0;
			end
			begin
				vin_target = VIN_PIXELS;
				while (vin_sent_q.size() < VIN_PIXELS)
					@(posedge sys_clk);
			end
			begin
				for (int i = 0; i < 6; i++)
					host_read_check(fml_adr_t'(FB_BASE + $urandom_range(0, FB_WORDS - 1)), 1'b0);
			end
		join

		target = host_acks + VIN_WORDS + FB_WORDS;
		while (transfers_o < meter_count_t'(target))
			@(negedge sys_clk);

		// Captured words hold pixels in arrival order, pixel 0 low
		for (int w = 0; w < VIN_WORDS; w++) begin
			for (int p = 0; p < PIX_PER_WORD; p++)
				expect_word[PIXEL_W*p +: PIXEL_W] = vin_sent_q[PIX_PER_WORD*w + p];
			host_access(1'b0, fml_adr_t'(VIN_BASE + w), '0, '0, 1'b1, data);
			assert (data == expect_word)
			else value_mismatch("host_rsp_o.dr capture word", data, expect_word);
		end

		assert (fb_pix_q.size() == FB_WORDS * PIX_PER_WORD)
		else value_mismatch("fb_pix_o beat count", fb_pix_q.size(), FB_WORDS * PIX_PER_WORD);
		for (int i = 0; i < fb_pix_q.size(); i++) begin
			expect_word = model_mem[FB_BASE + i / PIX_PER_WORD];
			expect_pix = expect_word[PIXEL_W*(i % PIX_PER_WORD) +: PIXEL_W];
			assert (fb_pix_q[i] == expect_pix)
			else value_mismatch("fb_pix_o.pix", fb_pix_q[i], expect_pix);
		end
		assert (fb_done_count == 1)
		else value_mismatch("fb_done_o pulse count", fb_done_count, 1);

		// Each transfer holds the slave strobe for latency plus grant
		@(negedge sys_clk);
		expect_xfers = host_acks + VIN_WORDS + FB_WORDS;
		assert (transfers_o == meter_count_t'(expect_xfers))
		else value_mismatch("transfers_o", transfers_o, expect_xfers);
		assert (busy_cycles_o == meter_count_t'(expect_xfers * (MEM_LATENCY + 1)))
		else value_mismatch("busy_cycles_o", busy_cycles_o, expect_xfers * (MEM_LATENCY + 1));

		if (u_video_mem_top.u_video_mem_assertions.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			plain_failure("A bound link assertion failed");
		end
	end

endmodule

`default_nettype wire

/* project.f */
video_mem_pkg.sv
fml_arbiter.sv
fml_ram.sv
fb_fetch.sv
vin_capture.sv
fml_meter.sv
video_mem_top.sv
video_mem_assertions.sv
tb_video_mem.sv

/* Bender.yml */
package:
  name: video_mem

sources:
  - video_mem_pkg.sv
  - fml_arbiter.sv
  - fml_ram.sv
  - fb_fetch.sv
  - vin_capture.sv
  - fml_meter.sv
  - video_mem_top.sv
  - target: test
    files:
      - video_mem_assertions.sv
      - tb_video_mem.sv
